// File: design/rename_pkg.sv
`default_nettype none

package rename_pkg;

  // sizes of the rename stage
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 64;
  localparam int NUM_ROB       = 16;                            // one checkpoint per rob entry
  localparam int NUM_FREE      = NUM_PHYS_REGS - NUM_ARCH_REGS; // tags not mapped at reset

  // index widths
  localparam int AR_W  = $clog2(NUM_ARCH_REGS); // 5
  localparam int PR_W  = $clog2(NUM_PHYS_REGS); // 6
  localparam int ROB_W = $clog2(NUM_ROB);       // 4
  localparam int FL_W  = $clog2(NUM_FREE);      // 5

  // first tag pushed into the free list during init
  localparam logic [PR_W-1:0] FIRST_FREE_TAG = PR_W'(NUM_ARCH_REGS);

  // reset map, arch reg i sits on tag i and is ready
  function automatic logic [PR_W-1:0] reset_tag(input int unsigned arch_reg);
    return PR_W'(arch_reg);
  endfunction

  // controller states
  typedef enum logic [1:0] {
    ST_INIT,    // filling free list
    ST_RUN,     // normal dispatch
    ST_RECOVER  // one dead cycle after rollback
  } rename_state_t;

endpackage

`default_nettype wire

// File: design/rename_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module rename_ctrl
  import rename_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            dispatch_en,
  input  logic            rollback_en,
  input  logic            empty,
  input  logic            full,
  output logic            dispatch_ready,
  output logic            alloc,
  output logic            init_push,
  output logic [PR_W-1:0] init_tag
);

  rename_state_t   state;
  rename_state_t   state_next;
  logic [PR_W-1:0] init_cnt;  // next tag to push during init

  // one push per cycle until the list reports full
  assign init_push = (state == ST_INIT) && !full;
  assign init_tag  = init_cnt;

  // dispatch only in run, with a tag available and no rollback this cycle
  assign dispatch_ready = (state == ST_RUN) && !empty && !rollback_en;
  assign alloc          = dispatch_en && dispatch_ready;

  always_comb begin
    state_next = state;
    case (state)
      ST_INIT:    if (full) state_next = ST_RUN;             // 32 tags loaded
      ST_RUN:     if (rollback_en) state_next = ST_RECOVER;
      ST_RECOVER: if (!rollback_en) state_next = ST_RUN;     // back-to-back rollback stays
      default:    state_next = ST_INIT;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= ST_INIT;
      init_cnt <= FIRST_FREE_TAG;
    end else begin
      state <= state_next;
      if (init_push) begin
        init_cnt <= init_cnt + 1'b1;  // 32 up to 63
      end
    end
  end

  // the fill ends with exactly NUM_FREE tags pushed
  assert property (@(posedge clock) disable iff (reset)
                   (state == ST_INIT && full) |->
                   init_cnt == PR_W'(FIRST_FREE_TAG + NUM_FREE))
    else $error("rename_ctrl: free list full before all init tags were pushed");

endmodule

`default_nettype wire

// File: design/free_list_ptrs.sv
`timescale 1ns/1ns
`default_nettype none

module free_list_ptrs
  import rename_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             init_push,
  input  logic             retire_en,
  input  logic             alloc,
  input  logic             rollback_en,
  input  logic [ROB_W-1:0] rollback_idx,
  input  logic [ROB_W-1:0] rob_tail_idx,
  output logic [FL_W-1:0]  head_idx,
  output logic [FL_W-1:0]  tail_idx,
  output logic             empty,
  output logic             full
);

  // extra msb is the wrap bit
  logic [FL_W:0] head;
  logic [FL_W:0] tail;
  logic [FL_W:0] head_inc;
  logic [FL_W:0] head_ckpt [NUM_ROB];  // head after each dispatch
  logic          push;

  assign push     = init_push || retire_en;
  assign head_inc = head + 1'b1;

  assign head_idx = head[FL_W-1:0];
  assign tail_idx = tail[FL_W-1:0];

  // same index, wrap bits tell empty from full
  assign empty = (head == tail);
  assign full  = (head[FL_W] != tail[FL_W]) && (head[FL_W-1:0] == tail[FL_W-1:0]);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;  // init fill or retired tag
      if (rollback_en) begin
        head <= head_ckpt[rollback_idx];  // rollback beats alloc
      end else if (alloc) begin
        head <= head_inc;
      end
    end
  end

  // checkpoint the advanced head under the dispatching rob slot
  always_ff @(posedge clock) begin
    if (alloc) head_ckpt[rob_tail_idx] <= head_inc;
  end

  assert property (@(posedge clock) disable iff (reset) push |-> !full)
    else $error("free_list_ptrs: push into full free list");

endmodule

`default_nettype wire

// File: design/free_tag_ram.sv
`timescale 1ns/1ns
`default_nettype none

// circular store of free physical tags
// written at the tail, read at the head
module free_tag_ram
  import rename_pkg::*;
(
  input  logic            clock,
  input  logic            write_en,
  input  logic [FL_W-1:0] write_idx,
  input  logic [PR_W-1:0] write_tag,
  input  logic [FL_W-1:0] read_idx,
  output logic [PR_W-1:0] read_tag
);

  logic [PR_W-1:0] mem [NUM_FREE];  // one slot per free tag

  // single write port, init fill or retire
  always_ff @(posedge clock) begin
    if (write_en) begin
      mem[write_idx] <= write_tag;
    end
  end

  // async read so the head tag is usable in the dispatch cycle
  assign read_tag = mem[read_idx];

endmodule

`default_nettype wire

// File: design/map_table.sv
`timescale 1ns/1ns
`default_nettype none

module map_table
  import rename_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             alloc,
  input  logic [AR_W-1:0]  reg_dest,
  input  logic [AR_W-1:0]  reg_a,
  input  logic [AR_W-1:0]  reg_b,
  input  logic [PR_W-1:0]  t_new,
  input  logic [ROB_W-1:0] rob_tail_idx,
  input  logic             cdb_en,
  input  logic [PR_W-1:0]  cdb_tag,
  input  logic             rollback_en,
  input  logic [ROB_W-1:0] rollback_idx,
  output logic [PR_W-1:0]  t_old,
  output logic [PR_W-1:0]  t1,
  output logic [PR_W-1:0]  t2,
  output logic             t1_ready,
  output logic             t2_ready
);

  // live map
  logic [PR_W-1:0]          map_tag [NUM_ARCH_REGS];
  logic [NUM_ARCH_REGS-1:0] map_rdy;

  // tag-only checkpoints, restored as all ready
  logic [PR_W-1:0]          ckpt_tag [NUM_ROB][NUM_ARCH_REGS];

  // map after rollback or wakeup, before own alloc
  logic [PR_W-1:0]          cur_tag [NUM_ARCH_REGS];
  logic [NUM_ARCH_REGS-1:0] cur_rdy;

  // map after alloc, goes to the regs and the checkpoint
  logic [PR_W-1:0]          nxt_tag [NUM_ARCH_REGS];
  logic [NUM_ARCH_REGS-1:0] nxt_rdy;

  always_comb begin
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      if (rollback_en) begin
        cur_tag[i] = ckpt_tag[rollback_idx][i];  // rollback wins over cdb
        cur_rdy[i] = 1'b1;                       // older producers assumed done
      end else begin
        cur_tag[i] = map_tag[i];
        // wake every entry holding the broadcast tag
        cur_rdy[i] = map_rdy[i] || (cdb_en && (map_tag[i] == cdb_tag));
      end
    end
  end

  // lookups see same-cycle cdb but not this cycle's rename
  assign t_old    = cur_tag[reg_dest];
  assign t1       = cur_tag[reg_a];
  assign t1_ready = cur_rdy[reg_a];
  assign t2       = cur_tag[reg_b];
  assign t2_ready = cur_rdy[reg_b];

  always_comb begin
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      nxt_tag[i] = cur_tag[i];
    end
    nxt_rdy = cur_rdy;
    if (alloc) begin
      nxt_tag[reg_dest] = t_new;  // fresh tag, producer still pending
      nxt_rdy[reg_dest] = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_tag[i] <= reset_tag(i);  // identity map
        map_rdy[i] <= 1'b1;
      end
    end else begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_tag[i] <= nxt_tag[i];
      end
      map_rdy <= nxt_rdy;
    end
  end

  // snapshot includes this dispatch's own mapping
  always_ff @(posedge clock) begin
    if (alloc) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        ckpt_tag[rob_tail_idx][i] <= nxt_tag[i];
      end
    end
  end

  // controller must block dispatch in a rollback cycle
  assert property (@(posedge clock) disable iff (reset) !(rollback_en && alloc))
    else $error("map_table: alloc together with rollback");

endmodule

`default_nettype wire

// File: design/rename_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rename_unit
  import rename_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch_en,
  input  logic [AR_W-1:0]  reg_dest,
  input  logic [AR_W-1:0]  reg_a,
  input  logic [AR_W-1:0]  reg_b,
  input  logic [ROB_W-1:0] rob_tail_idx,
  input  logic             cdb_en,
  input  logic [PR_W-1:0]  cdb_tag,
  input  logic             retire_en,
  input  logic [PR_W-1:0]  retire_told,
  input  logic             rollback_en,
  input  logic [ROB_W-1:0] rollback_idx,
  output logic             dispatch_ready,
  output logic [PR_W-1:0]  t_new,
  output logic [PR_W-1:0]  t_old,
  output logic [PR_W-1:0]  t1,
  output logic             t1_ready,
  output logic [PR_W-1:0]  t2,
  output logic             t2_ready
);

  logic            alloc;
  logic            init_push;
  logic [PR_W-1:0] init_tag;
  logic [FL_W-1:0] head_idx;
  logic [FL_W-1:0] tail_idx;
  logic            empty;
  logic            full;
  logic [PR_W-1:0] free_tag;  // head of free list
  logic [PR_W-1:0] ram_wr_tag;

  assign ram_wr_tag = init_push ? init_tag : retire_told;  // init fill, then retired tags
  assign t_new      = free_tag;

  rename_ctrl u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .empty          (empty),
    .full           (full),
    .dispatch_ready (dispatch_ready),
    .alloc          (alloc),
    .init_push      (init_push),
    .init_tag       (init_tag)
  );

  free_list_ptrs u_ptrs (
    .clock        (clock),
    .reset        (reset),
    .init_push    (init_push),
    .retire_en    (retire_en),
    .alloc        (alloc),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail_idx (rob_tail_idx),
    .head_idx     (head_idx),
    .tail_idx     (tail_idx),
    .empty        (empty),
    .full         (full)
  );

  free_tag_ram u_ram (
    .clock     (clock),
    .write_en  (init_push || retire_en),
    .write_idx (tail_idx),
    .write_tag (ram_wr_tag),
    .read_idx  (head_idx),
    .read_tag  (free_tag)
  );

  map_table u_map (
    .clock        (clock),
    .reset        (reset),
    .alloc        (alloc),
    .reg_dest     (reg_dest),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .t_new        (free_tag),
    .rob_tail_idx (rob_tail_idx),
    .cdb_en       (cdb_en),
    .cdb_tag      (cdb_tag),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .t_old        (t_old),
    .t1           (t1),
    .t2           (t2),
    .t1_ready     (t1_ready),
    .t2_ready     (t2_ready)
  );

endmodule

`default_nettype wire

// File: dv/rename_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rename_unit_tb
  import rename_pkg::*;
;

  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DELAY   = 2;   // inputs change after the edge
  localparam int RESET_CYCLES  = 4;
  localparam int INIT_CYCLES   = 32;  // free list fill
  localparam int NUM_RESETS    = 4;
  localparam int DIRECTED_LEN  = 120; // tests 1 to 5 rounded up
  localparam int RANDOM_CYCLES = 400;
  localparam int TIMEOUT_CYCLES = NUM_RESETS * (RESET_CYCLES + INIT_CYCLES + 4)
                                + DIRECTED_LEN + RANDOM_CYCLES + 200;

  logic             clock;
  logic             reset;
  logic             dispatch_en;
  logic [AR_W-1:0]  reg_dest;
  logic [AR_W-1:0]  reg_a;
  logic [AR_W-1:0]  reg_b;
  logic [ROB_W-1:0] rob_tail_idx;
  logic             cdb_en;
  logic [PR_W-1:0]  cdb_tag;
  logic             retire_en;
  logic [PR_W-1:0]  retire_told;
  logic             rollback_en;
  logic [ROB_W-1:0] rollback_idx;
  logic             dispatch_ready;
  logic [PR_W-1:0]  t_new;
  logic [PR_W-1:0]  t_old;
  logic [PR_W-1:0]  t1;
  logic             t1_ready;
  logic [PR_W-1:0]  t2;
  logic             t2_ready;

  // reference state
  logic [PR_W-1:0]  m_map [NUM_ARCH_REGS];
  logic             m_rdy [NUM_ARCH_REGS];
  logic [PR_W-1:0]  m_fl [NUM_FREE];   // circular free queue
  int               m_head;
  int               m_tail;            // free count is tail - head
  int               m_hckpt [NUM_ROB];
  logic [PR_W-1:0]  m_ckpt [NUM_ROB][NUM_ARCH_REGS];
  logic             m_recover;
  logic             m_run;             // set once the DUT leaves init

  // live rob entries with the oldest first
  logic [ROB_W-1:0] rob_q_idx [$];
  logic [PR_W-1:0]  rob_q_told [$];
  logic [ROB_W-1:0] next_rob;

  logic [31:0]      lfsr = 32'hd395b1c5;
  string            test_name = "reset";
  logic             ready_seen;
  int               cycle_cnt = 0;

  // expected outputs of the current cycle
  logic             e_ready;
  logic [PR_W-1:0]  e_new;
  logic [PR_W-1:0]  e_old;
  logic [PR_W-1:0]  e_t1;
  logic             e_t1r;
  logic [PR_W-1:0]  e_t2;
  logic             e_t2r;

  rename_unit UUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .reg_dest       (reg_dest),
    .reg_a          (reg_a),
    .reg_b          (reg_b),
    .rob_tail_idx   (rob_tail_idx),
    .cdb_en         (cdb_en),
    .cdb_tag        (cdb_tag),
    .retire_en      (retire_en),
    .retire_told    (retire_told),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .dispatch_ready (dispatch_ready),
    .t_new          (t_new),
    .t_old          (t_old),
    .t1             (t1),
    .t1_ready       (t1_ready),
    .t2             (t2),
    .t2_ready       (t2_ready)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | 32'(lfsr_bit());  // one step per bit
    end
    return v;
  endfunction

  task automatic check_value(input string sig, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR test=%s signal=%s expected=%0d actual=%0d",
               test_name, sig, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  // identity map and tags 32..63 queued in order
  function automatic void clear_model();
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      m_map[i] = PR_W'(i);
      m_rdy[i] = 1'b1;
      m_fl[i]  = PR_W'(NUM_ARCH_REGS + i);
    end
    m_head    = 0;
    m_tail    = NUM_FREE;
    m_recover = 1'b0;
    m_run     = 1'b0;
    next_rob  = '0;
    rob_q_idx.delete();
    rob_q_told.delete();
  endfunction

  // one clock of the rename rules giving what the outputs must show
  function automatic void model_step(output logic e_rdy, output logic [PR_W-1:0] e_tn,
                                     output logic [PR_W-1:0] e_to, output logic [PR_W-1:0] e_a,
                                     output logic e_ar, output logic [PR_W-1:0] e_b,
                                     output logic e_br);
    logic [PR_W-1:0] cur_tag [NUM_ARCH_REGS];
    logic            cur_rdy [NUM_ARCH_REGS];
    logic            take;
    e_rdy = m_run && !m_recover && (m_tail - m_head > 0) && !rollback_en;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      if (rollback_en) begin
        cur_tag[i] = m_ckpt[rollback_idx][i];  // restore with everything ready
        cur_rdy[i] = 1'b1;
      end else begin
        cur_tag[i] = m_map[i];
        cur_rdy[i] = m_rdy[i] || (cdb_en && m_map[i] == cdb_tag);
      end
    end
    e_tn = m_fl[m_head % NUM_FREE];
    e_to = cur_tag[reg_dest];  // read before own rename
    e_a  = cur_tag[reg_a];
    e_ar = cur_rdy[reg_a];
    e_b  = cur_tag[reg_b];
    e_br = cur_rdy[reg_b];
    take = dispatch_en && e_rdy;
    if (take) begin
      cur_tag[reg_dest] = e_tn;
      cur_rdy[reg_dest] = 1'b0;
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        m_ckpt[rob_tail_idx][i] = cur_tag[i];  // map incl. this dispatch
      end
      m_hckpt[rob_tail_idx] = m_head + 1;
    end
    if (retire_en) begin
      m_fl[m_tail % NUM_FREE] = retire_told;
      m_tail++;
    end
    if (rollback_en) m_head = m_hckpt[rollback_idx];
    else if (take) m_head++;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      m_map[i] = cur_tag[i];
      m_rdy[i] = cur_rdy[i];
    end
    m_recover = rollback_en;  // one dead cycle per rollback
  endfunction

  // rob bookkeeping for retire and rollback targets
  function automatic void track_rob(input logic accepted, input logic [PR_W-1:0] told);
    if (rollback_en) begin
      while (rob_q_idx.size() > 0 && rob_q_idx[rob_q_idx.size()-1] != rollback_idx) begin
        void'(rob_q_idx.pop_back());  // squash younger entries
        void'(rob_q_told.pop_back());
      end
      next_rob = rollback_idx + 4'd1;
    end
    if (retire_en && rob_q_idx.size() > 0) begin
      void'(rob_q_idx.pop_front());
      void'(rob_q_told.pop_front());
    end
    if (accepted) begin
      rob_q_idx.push_back(rob_tail_idx);
      rob_q_told.push_back(told);
      next_rob = rob_tail_idx + 4'd1;
    end
  endfunction

  // compare 2 ns before each rising edge
  initial begin
    forever begin
      @(posedge clock);
      #(CLK_PERIOD - DRIVE_DELAY);
      if (!reset) begin
        if (!m_run && dispatch_ready) begin
          m_run      = 1'b1;  // init done
          ready_seen = 1'b1;
        end
        if (m_run) begin
          model_step(e_ready, e_new, e_old, e_t1, e_t1r, e_t2, e_t2r);
          check_value("dispatch_ready", 32'(e_ready), 32'(dispatch_ready));
          if (e_ready) begin
            check_value("t_new", 32'(e_new), 32'(t_new));
            check_value("t_old", 32'(e_old), 32'(t_old));
            check_value("t1", 32'(e_t1), 32'(t1));
            check_value("t1_ready", 32'(e_t1r), 32'(t1_ready));
            check_value("t2", 32'(e_t2), 32'(t2));
            check_value("t2_ready", 32'(e_t2r), 32'(t2_ready));
          end
          track_rob(e_ready && dispatch_en, e_old);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      if (!ready_seen) $display("timeout, dispatch_ready never rose");
      else $display("timeout, tests did not finish");
      $display("TESTS FAILED");
      $fatal(1, "run stopped at the cycle limit");
    end
  end

  task automatic idle_inputs();
    dispatch_en  = 1'b0;
    reg_dest     = '0;
    reg_a        = '0;
    reg_b        = '0;
    rob_tail_idx = '0;
    cdb_en       = 1'b0;
    cdb_tag      = '0;
    retire_en    = 1'b0;
    retire_told  = '0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #DRIVE_DELAY;
    idle_inputs();
  endtask

  task automatic drive_dispatch(input int dest, input int a, input int b, input int rob);
    dispatch_en  = 1'b1;
    reg_dest     = AR_W'(dest);
    reg_a        = AR_W'(a);
    reg_b        = AR_W'(b);
    rob_tail_idx = ROB_W'(rob);
  endtask

  // reset for 4 cycles then wait for the free list fill
  task automatic reset_dut();
    next_cycle();  // let the last driven cycle be compared
    reset      = 1'b1;
    ready_seen = 1'b0;
    idle_inputs();
    clear_model();
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    while (!m_run) @(posedge clock);
  endtask

  task automatic lookup_reset_map();
    test_name = "reset_map";
    reset_dut();
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      next_cycle();
      reg_dest = AR_W'(i);  // lookup only without dispatch
      reg_a    = AR_W'(i);
      reg_b    = AR_W'(NUM_ARCH_REGS - 1 - i);
    end
  endtask

  task automatic dispatch_in_order();
    test_name = "alloc_order";
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      drive_dispatch((i * 3) % 7, ((i + 6) * 3) % 7, (i * 3) % 7, i);  // a = previous dest
    end
  endtask

  task automatic wake_on_cdb();
    test_name = "cdb_wakeup";
    next_cycle();
    reg_a   = 5'd0;
    reg_b   = 5'd3;
    cdb_en  = 1'b1;
    cdb_tag = m_map[0];  // pending tag of r0
    next_cycle();
    reg_a = 5'd0;        // now registered ready
    next_cycle();
    drive_dispatch(9, 3, 9, 10);
    cdb_en  = 1'b1;
    cdb_tag = m_map[3];  // wakeup during dispatch
  endtask

  task automatic exhaust_and_retire();
    test_name = "exhaust_retire";
    reset_dut();
    for (int i = 0; i < NUM_FREE; i++) begin
      next_cycle();
      drive_dispatch(i, (i + 1) % NUM_ARCH_REGS, i, i % NUM_ROB);
    end
    next_cycle();
    drive_dispatch(5, 1, 2, 0);  // ignored as the list is empty
    next_cycle();
    retire_en   = 1'b1;
    retire_told = rob_q_told[0];
    next_cycle();
    drive_dispatch(7, 7, 0, 1);  // gets the retired tag
  endtask

  task automatic roll_back_to_checkpoint();
    test_name = "rollback";
    reset_dut();
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      drive_dispatch(i + 1, i, i + 1, i);
    end
    next_cycle();
    rollback_en  = 1'b1;
    rollback_idx = 4'd2;
    dispatch_en  = 1'b1;         // loses to rollback
    next_cycle();
    drive_dispatch(9, 0, 0, 3);  // recovery cycle so ignored
    for (int i = 0; i < NUM_ARCH_REGS / 2; i++) begin
      next_cycle();
      reg_a = AR_W'(2 * i);
      reg_b = AR_W'(2 * i + 1);
    end
    next_cycle();
    drive_dispatch(10, 3, 4, 3);
  endtask

  task automatic random_cycle();
    int   k;
    logic can_disp;
    next_cycle();
    can_disp = m_run && !m_recover && (m_tail - m_head > 0);
    if (rob_q_idx.size() > 0 && rand_bits(4) == 0) begin
      k            = int'(rand_bits(4)) % rob_q_idx.size();
      rollback_en  = 1'b1;
      rollback_idx = rob_q_idx[k];  // live checkpoint only
    end else if (rob_q_idx.size() < NUM_ROB) begin
      if (rob_q_idx.size() > 0 && rand_bits(2) == 0) begin
        retire_en   = 1'b1;
        retire_told = rob_q_told[0];  // oldest entry commits
      end
      if (can_disp && rand_bits(1) == 1) begin
        drive_dispatch(int'(rand_bits(AR_W)), int'(rand_bits(AR_W)),
                       int'(rand_bits(AR_W)), int'(next_rob));
      end
    end else begin
      retire_en   = 1'b1;  // rob full so drain one
      retire_told = rob_q_told[0];
    end
    if (rand_bits(1) == 1) begin
      cdb_en  = 1'b1;
      cdb_tag = PR_W'(rand_bits(PR_W));
    end
  endtask

  initial begin
    reset = 1'b1;
    idle_inputs();
    lookup_reset_map();
    dispatch_in_order();
    wake_on_cdb();
    exhaust_and_retire();
    roll_back_to_checkpoint();
    test_name = "random_mix";
    reset_dut();
    repeat (RANDOM_CYCLES) random_cycle();
    next_cycle();
    next_cycle();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_unit.f
design/rename_pkg.sv
design/rename_ctrl.sv
design/free_list_ptrs.sv
design/free_tag_ram.sv
design/map_table.sv
design/rename_unit.sv
dv/rename_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the rename unit testbench with verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f rename_unit.f \
  --top-module rename_unit_tb -o rename_unit_sim > build.log 2>&1 \
  && ./obj_dir/rename_unit_sim > sim.log 2>&1
cat build.log sim.log 2> /dev/null

grep -q "^TESTS PASSED$" sim.log 2> /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
